//--- design/core.sv
`timescale 1ns/1ps

module core (
  input  logic              i_clk,
  input  logic              i_rst,
  output cpu_pkg::mem_req_t o_mem_req,
  input  cpu_pkg::word_t    i_mem_rdata,
  output logic              o_invalid_inst,
  output cpu_pkg::addr_t    o_pc
);
  import cpu_pkg::*;

  core_state_e state;
  addr_t       pc;
  logic        invalid_q;

  logic     fetch_rst, fetch_started, fetch_ready;
  mem_req_t fetch_req;
  word_t    fetch_rdata;
  word_t    inst;

  logic     exec_rst, exec_ready, exec_invalid, exec_pc_change;
  mem_req_t exec_req;
  word_t    exec_rdata;
  addr_t    exec_new_pc;

  // Idle stage is held in reset
  assign fetch_rst = i_rst || (state != CORE_FETCH);
  assign exec_rst  = i_rst || (state != CORE_EXECUTE);

  always_comb begin
    o_mem_req   = '0;
    fetch_rdata = '0;
    exec_rdata  = '0;
    case (state)
      CORE_FETCH: begin
        o_mem_req   = fetch_req;
        fetch_rdata = i_mem_rdata;
      end
      CORE_EXECUTE: begin
        o_mem_req  = exec_req;
        exec_rdata = i_mem_rdata;
      end
      default: o_mem_req = '0;  // No traffic in halt
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state     <= CORE_FETCH;
      pc        <= '0;
      invalid_q <= 1'b0;
    end else begin
      case (state)
        CORE_FETCH: if (fetch_started && fetch_ready) state <= CORE_EXECUTE;
        CORE_EXECUTE: begin
          if (exec_invalid) begin
            state     <= CORE_HALT;
            invalid_q <= 1'b1;
          end else if (exec_ready) begin
            pc    <= exec_pc_change ? exec_new_pc : pc + 32'd4;
            state <= CORE_FETCH;
          end
        end
        default: state <= CORE_HALT;  // Only reset leaves halt
      endcase
    end
  end

  fetch u_fetch (
    .i_clk       (i_clk),
    .i_rst       (fetch_rst),
    .i_pc        (pc),
    .o_mem_req   (fetch_req),
    .i_mem_rdata (fetch_rdata),
    .o_inst      (inst),
    .o_started   (fetch_started),
    .o_ready     (fetch_ready)
  );

  execute u_execute (
    .i_clk          (i_clk),
    .i_rst          (exec_rst),
    .i_rf_rst       (i_rst),
    .i_inst         (inst),
    .i_pc           (pc),
    .o_mem_req      (exec_req),
    .i_mem_rdata    (exec_rdata),
    .o_pc_change    (exec_pc_change),
    .o_new_pc       (exec_new_pc),
    .o_ready        (exec_ready),
    .o_invalid_inst (exec_invalid)
  );

  assign o_pc           = pc;
  assign o_invalid_inst = invalid_q;

endmodule

//--- design/cpu_pkg.sv
package cpu_pkg;

  typedef logic [31:0] word_t;
  typedef logic [31:0] addr_t;
  typedef logic [4:0]  reg_idx_t;

  localparam int MEM_WORDS = 1024;
  typedef logic [$clog2(MEM_WORDS)-1:0] mem_idx_t;  // Byte address bits 11:2

  // Major opcodes
  localparam logic [6:0] OP_IMM    = 7'b0010011;
  localparam logic [6:0] OP_REG    = 7'b0110011;
  localparam logic [6:0] OP_LUI    = 7'b0110111;
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_JAL    = 7'b1101111;

  localparam logic [2:0] F3_ADD  = 3'b000;
  localparam logic [2:0] F3_XOR  = 3'b100;
  localparam logic [2:0] F3_OR   = 3'b110;
  localparam logic [2:0] F3_AND  = 3'b111;
  localparam logic [2:0] F3_WORD = 3'b010;  // LW / SW
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;

  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_SUB  = 7'b0100000;

  typedef struct packed {
    addr_t addr;
    word_t wdata;
    logic  we;
  } mem_req_t;

  typedef struct packed {
    reg_idx_t   rd;
    reg_idx_t   rs1;
    reg_idx_t   rs2;
    logic [2:0] funct3;
    word_t      imm;
    logic       is_alu;
    logic       use_rs2;  // Register operand instead of immediate
    logic       sub;
    logic       is_lui;
    logic       is_load;
    logic       is_store;
    logic       is_branch;
    logic       is_jal;
    logic       valid;
  } dec_inst_t;

  typedef enum logic [1:0] {
    CORE_FETCH,
    CORE_EXECUTE,
    CORE_HALT
  } core_state_e;

  typedef enum logic {
    EX_RUN,
    EX_LOAD_WB
  } exec_state_e;

endpackage

//--- design/cpu_top.sv
`timescale 1ns/1ps

module cpu_top (
  input  logic              i_clk,
  input  logic              i_rst,

  // Host port for program load and readback
  input  logic              i_host_we,
  input  cpu_pkg::mem_idx_t i_host_idx,
  input  cpu_pkg::word_t    i_host_wdata,
  output cpu_pkg::word_t    o_host_rdata,

  output cpu_pkg::addr_t    o_pc,
  output logic              o_invalid_inst
);
  import cpu_pkg::*;

  mem_req_t mem_req;
  word_t    mem_rdata;

  core u_core (
    .i_clk          (i_clk),
    .i_rst          (i_rst),
    .o_mem_req      (mem_req),
    .i_mem_rdata    (mem_rdata),
    .o_invalid_inst (o_invalid_inst),
    .o_pc           (o_pc)
  );

  unified_mem u_mem (
    .i_clk        (i_clk),
    .i_req        (mem_req),
    .o_rdata      (mem_rdata),
    .i_host_we    (i_host_we),
    .i_host_idx   (i_host_idx),
    .i_host_wdata (i_host_wdata),
    .o_host_rdata (o_host_rdata)
  );

endmodule

//--- design/execute.sv
`timescale 1ns/1ps

module execute (
  input  logic              i_clk,
  input  logic              i_rst,
  input  logic              i_rf_rst,
  input  cpu_pkg::word_t    i_inst,
  input  cpu_pkg::addr_t    i_pc,
  output cpu_pkg::mem_req_t o_mem_req,
  input  cpu_pkg::word_t    i_mem_rdata,
  output logic              o_pc_change,
  output cpu_pkg::addr_t    o_new_pc,
  output logic              o_ready,
  output logic              o_invalid_inst
);
  import cpu_pkg::*;

  exec_state_e ex_state;
  dec_inst_t   dec;
  word_t       rs1_data;
  word_t       rs2_data;
  word_t       op_b;
  word_t       alu_result;
  word_t       wb_data;
  word_t       rf_wdata;
  logic        rf_we;
  logic        taken;

  // Decode
  always_comb begin
    logic [6:0] funct7;
    funct7     = i_inst[31:25];
    dec        = '0;
    dec.rd     = i_inst[11:7];
    dec.rs1    = i_inst[19:15];
    dec.rs2    = i_inst[24:20];
    dec.funct3 = i_inst[14:12];
    case (i_inst[6:0])
      OP_IMM: begin
        dec.is_alu = 1'b1;
        dec.imm    = {{20{i_inst[31]}}, i_inst[31:20]};
        dec.valid  = (dec.funct3 == F3_ADD);
      end
      OP_REG: begin
        dec.is_alu  = 1'b1;
        dec.use_rs2 = 1'b1;
        dec.sub     = (funct7 == F7_SUB);
        dec.valid   = ((funct7 == F7_BASE) &&
                       (dec.funct3 inside {F3_ADD, F3_XOR, F3_OR, F3_AND})) ||
                      ((funct7 == F7_SUB) && (dec.funct3 == F3_ADD));
      end
      OP_LUI: begin
        dec.is_lui = 1'b1;
        dec.imm    = {i_inst[31:12], 12'b0};
        dec.valid  = 1'b1;
      end
      OP_LOAD: begin
        dec.is_load = 1'b1;
        dec.imm     = {{20{i_inst[31]}}, i_inst[31:20]};
        dec.valid   = (dec.funct3 == F3_WORD);
      end
      OP_STORE: begin
        dec.is_store = 1'b1;
        dec.imm      = {{20{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
        dec.valid    = (dec.funct3 == F3_WORD);
      end
      OP_BRANCH: begin
        dec.is_branch = 1'b1;
        dec.imm       = {{19{i_inst[31]}}, i_inst[31], i_inst[7],
                         i_inst[30:25], i_inst[11:8], 1'b0};
        dec.valid     = (dec.funct3 == F3_BEQ) || (dec.funct3 == F3_BNE);
      end
      OP_JAL: begin
        dec.is_jal = 1'b1;
        dec.imm    = {{11{i_inst[31]}}, i_inst[31], i_inst[19:12],
                      i_inst[20], i_inst[30:21], 1'b0};
        dec.valid  = 1'b1;
      end
      default: dec.valid = 1'b0;  // Includes the all-zero word
    endcase
  end

  reg_file u_reg_file (
    .i_clk      (i_clk),
    .i_rst      (i_rf_rst),
    .i_rs1      (dec.rs1),
    .i_rs2      (dec.rs2),
    .o_rs1_data (rs1_data),
    .o_rs2_data (rs2_data),
    .i_we       (rf_we),
    .i_rd       (dec.rd),
    .i_rd_data  (rf_wdata)
  );

  assign op_b = dec.use_rs2 ? rs2_data : dec.imm;

  always_comb begin
    case (dec.funct3)
      F3_XOR:  alu_result = rs1_data ^ op_b;
      F3_OR:   alu_result = rs1_data | op_b;
      F3_AND:  alu_result = rs1_data & op_b;
      default: alu_result = dec.sub ? (rs1_data - op_b) : (rs1_data + op_b);
    endcase
  end

  always_comb begin
    if (dec.is_lui) wb_data = dec.imm;
    else if (dec.is_jal) wb_data = i_pc + 32'd4;  // Link address
    else wb_data = alu_result;
  end

  // No writes while the stage sits in reset during fetch
  assign rf_we = !i_rst && dec.valid &&
                 (((ex_state == EX_RUN) && (dec.is_alu || dec.is_lui || dec.is_jal)) ||
                  (ex_state == EX_LOAD_WB));
  assign rf_wdata = (ex_state == EX_LOAD_WB) ? i_mem_rdata : wb_data;

  assign taken = (rs1_data == rs2_data) ^ (dec.funct3 == F3_BNE);

  assign o_pc_change    = dec.is_jal || (dec.is_branch && taken);
  assign o_new_pc       = i_pc + dec.imm;
  assign o_ready        = (ex_state == EX_LOAD_WB) || (dec.valid && !dec.is_load);
  assign o_invalid_inst = !dec.valid;

  // Byte and halfword stores are invalid and never reach memory
  always_comb begin
    o_mem_req       = '0;
    o_mem_req.addr  = rs1_data + dec.imm;
    o_mem_req.wdata = rs2_data;
    o_mem_req.we    = dec.valid && dec.is_store && (ex_state == EX_RUN);
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      ex_state <= EX_RUN;
    end else begin
      case (ex_state)
        EX_RUN:     if (dec.valid && dec.is_load) ex_state <= EX_LOAD_WB;
        EX_LOAD_WB: ex_state <= EX_RUN;
        default:    ex_state <= EX_RUN;
      endcase
    end
  end

endmodule

//--- design/fetch.sv
`timescale 1ns/1ps

module fetch (
  input  logic              i_clk,
  input  logic              i_rst,
  input  cpu_pkg::addr_t    i_pc,
  output cpu_pkg::mem_req_t o_mem_req,
  input  cpu_pkg::word_t    i_mem_rdata,
  output cpu_pkg::word_t    o_inst,
  output logic              o_started,
  output logic              o_ready
);
  import cpu_pkg::*;

  logic started;

  // Read at the PC is presented from the first cycle out of reset
  always_comb begin
    o_mem_req       = '0;
    o_mem_req.addr  = i_pc;
    o_mem_req.wdata = '0;
    o_mem_req.we    = 1'b0;
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      started <= 1'b0;
    end else begin
      started <= 1'b1;
    end
  end

  // Kept through reset so execute still decodes it
  always_ff @(posedge i_clk) begin
    if (!i_rst && started) begin
      o_inst <= i_mem_rdata;
    end
  end

  assign o_started = started;
  assign o_ready   = started;  // Word arrives now and is latched at this edge

endmodule

//--- design/reg_file.sv
`timescale 1ns/1ps

module reg_file (
  input  logic              i_clk,
  input  logic              i_rst,
  input  cpu_pkg::reg_idx_t i_rs1,
  input  cpu_pkg::reg_idx_t i_rs2,
  output cpu_pkg::word_t    o_rs1_data,
  output cpu_pkg::word_t    o_rs2_data,
  input  logic              i_we,
  input  cpu_pkg::reg_idx_t i_rd,
  input  cpu_pkg::word_t    i_rd_data
);
  import cpu_pkg::*;

  // x0 has no storage
  word_t regs [31:1];

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (i_we && (i_rd != '0)) begin
      regs[i_rd] <= i_rd_data;
    end
  end

  always_comb begin
    o_rs1_data = '0;
    o_rs2_data = '0;
    if (i_rs1 != '0) o_rs1_data = regs[i_rs1];
    if (i_rs2 != '0) o_rs2_data = regs[i_rs2];
  end

endmodule

//--- design/unified_mem.sv
`timescale 1ns/1ps

module unified_mem (
  input  logic              i_clk,
  input  cpu_pkg::mem_req_t i_req,
  output cpu_pkg::word_t    o_rdata,
  input  logic              i_host_we,
  input  cpu_pkg::mem_idx_t i_host_idx,
  input  cpu_pkg::word_t    i_host_wdata,
  output cpu_pkg::word_t    o_host_rdata
);
  import cpu_pkg::*;

  word_t    mem [MEM_WORDS];
  mem_idx_t core_idx;

  // Word index from the byte address
  assign core_idx = i_req.addr[$bits(mem_idx_t)+1:2];

  always_ff @(posedge i_clk) begin
    if (i_req.we) begin
      mem[core_idx] <= i_req.wdata;
    end
    if (i_host_we) begin
      mem[i_host_idx] <= i_host_wdata;  // Host loads only while core is in reset
    end
  end

  always_ff @(posedge i_clk) begin
    o_rdata      <= mem[core_idx];
    o_host_rdata <= mem[i_host_idx];
  end

endmodule

//--- dv/cpu_tb.sv
`timescale 1ns/1ps

module cpu_tb;
  import cpu_pkg::*;

  localparam int DATA_BASE    = 64;    // Result area at byte 0x100
  localparam int FILL_WORDS   = 128;
  localparam int RESET_CYCLES = 16;
  localparam int HALT_LIMIT   = 3000;
  localparam int NUM_TESTS    = 6;
  // Fill, reset hold, run bound and readback for every test
  localparam int WATCHDOG_CYCLES = NUM_TESTS * (FILL_WORDS + RESET_CYCLES + HALT_LIMIT + 100);

  logic     clk;
  logic     rst;
  logic     host_we;
  mem_idx_t host_idx;
  word_t    host_wdata;
  word_t    host_rdata;
  addr_t    pc;
  logic     invalid;
  int       errors;
  int       tests_run;
  word_t    prog [$];

  cpu_top UUT (
    .i_clk          (clk),
    .i_rst          (rst),
    .i_host_we      (host_we),
    .i_host_idx     (host_idx),
    .i_host_wdata   (host_wdata),
    .o_host_rdata   (host_rdata),
    .o_pc           (pc),
    .o_invalid_inst (invalid)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;  // 100 ns period
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("Verification failed");
    $finish;
  end

  function automatic word_t addi(reg_idx_t rd, reg_idx_t rs1, logic [11:0] imm);
    return {imm, rs1, F3_ADD, rd, OP_IMM};
  endfunction

  function automatic word_t lui(reg_idx_t rd, logic [19:0] imm);
    return {imm, rd, OP_LUI};
  endfunction

  function automatic word_t rtype(logic [6:0] f7, logic [2:0] f3, reg_idx_t rd,
                                  reg_idx_t rs1, reg_idx_t rs2);
    return {f7, rs2, rs1, f3, rd, OP_REG};
  endfunction

  function automatic word_t lw(reg_idx_t rd, reg_idx_t rs1, logic [11:0] imm);
    return {imm, rs1, F3_WORD, rd, OP_LOAD};
  endfunction

  function automatic word_t sw(reg_idx_t rs2, reg_idx_t rs1, logic [11:0] imm);
    return {imm[11:5], rs2, rs1, F3_WORD, imm[4:0], OP_STORE};
  endfunction

  function automatic word_t branch(logic [2:0] f3, reg_idx_t rs1, reg_idx_t rs2,
                                   logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OP_BRANCH};
  endfunction

  function automatic word_t jal(reg_idx_t rd, logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, OP_JAL};
  endfunction

  function automatic logic [11:0] slot_addr(int slot);
    return 12'(DATA_BASE * 4 + slot * 4);
  endfunction

  // Never zero, so a skipped store stays visible
  function automatic word_t fill_word(mem_idx_t idx);
    return {idx, ~idx, 12'hA5C};
  endfunction

  // LUI plus ADDI with the upper part rounded for the signed low half
  task automatic push_const(input reg_idx_t rd, input word_t value);
    word_t upper;
    upper = (value + 32'h800) >> 12;
    prog.push_back(lui(rd, upper[19:0]));
    prog.push_back(addi(rd, rd, value[11:0]));
  endtask

  task automatic flag_error(input string msg);
    errors++;
    $display("FAILED at %0t: %s", $time, msg);
  endtask

  task automatic host_write(input mem_idx_t idx, input word_t data);
    host_we    = 1'b1;
    host_idx   = idx;
    host_wdata = data;
    @(posedge clk);
    #1;
    host_we = 1'b0;
  endtask

  task automatic host_read(input mem_idx_t idx, output word_t data);
    host_idx = idx;
    @(posedge clk);
    #1;
    data = host_rdata;
  endtask

  task automatic check_slot(input int slot, input word_t exp, input string what);
    word_t got;
    host_read(mem_idx_t'(DATA_BASE + slot), got);
    if (got !== exp) begin
      flag_error($sformatf("%s: expected %08h, got %08h", what, exp, got));
    end
  endtask

  task automatic load_program();
    rst = 1'b1;
    for (int i = 0; i < FILL_WORDS; i++) begin
      host_write(mem_idx_t'(i), fill_word(mem_idx_t'(i)));
    end
    foreach (prog[i]) begin
      host_write(mem_idx_t'(i), prog[i]);
    end
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
  endtask

  task automatic wait_halt();
    int    cycles;
    addr_t end_pc;
    end_pc = addr_t'((prog.size() - 1) * 4);  // Address of the terminating word
    cycles = 0;
    rst    = 1'b0;
    while (!invalid && cycles < HALT_LIMIT) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if (!invalid) begin
      errors++;
      $display("Program did not reach its terminating word within %0d cycles", HALT_LIMIT);
    end else if (pc !== end_pc) begin
      flag_error($sformatf("halt pc: expected %08h, got %08h", end_pc, pc));
    end
  endtask

  task automatic reset_state();
    tests_run++;
    prog.delete();
    prog.push_back(addi(5'd1, 5'd0, 12'd1));
    prog.push_back(32'h0);
    load_program();
    if (pc !== '0 || invalid !== 1'b0) begin
      flag_error($sformatf("in reset: pc=%08h invalid=%b", pc, invalid));
    end
    rst = 1'b0;
    @(posedge clk);
    #1;
    if (pc !== '0 || invalid !== 1'b0) begin
      flag_error($sformatf("after reset: pc=%08h invalid=%b", pc, invalid));
    end
    wait_halt();
  endtask

  task automatic alu_ops();
    word_t       a;
    word_t       b;
    logic [11:0] imm;
    tests_run++;
    a   = $urandom();
    b   = $urandom();
    imm = 12'($urandom());
    prog.delete();
    push_const(5'd1, a);
    push_const(5'd2, b);
    prog.push_back(rtype(F7_BASE, F3_ADD, 5'd3, 5'd1, 5'd2));
    prog.push_back(rtype(F7_SUB,  F3_ADD, 5'd4, 5'd1, 5'd2));
    prog.push_back(rtype(F7_BASE, F3_AND, 5'd5, 5'd1, 5'd2));
    prog.push_back(rtype(F7_BASE, F3_OR,  5'd6, 5'd1, 5'd2));
    prog.push_back(rtype(F7_BASE, F3_XOR, 5'd7, 5'd1, 5'd2));
    prog.push_back(addi(5'd8, 5'd1, imm));
    for (int k = 0; k < 6; k++) begin
      prog.push_back(sw(reg_idx_t'(k + 3), 5'd0, slot_addr(k)));
    end
    prog.push_back(32'h0);
    load_program();
    wait_halt();
    check_slot(0, a + b, "ADD");
    check_slot(1, a - b, "SUB");
    check_slot(2, a & b, "AND");
    check_slot(3, a | b, "OR");
    check_slot(4, a ^ b, "XOR");
    check_slot(5, a + {{20{imm[11]}}, imm}, "ADDI");
  endtask

  task automatic load_store();
    word_t vals [4];
    word_t sum;
    tests_run++;
    sum = '0;
    prog.delete();
    for (int k = 0; k < 4; k++) begin
      vals[k] = $urandom();
      sum     = sum + vals[k];
      push_const(reg_idx_t'(k + 1), vals[k]);
      prog.push_back(sw(reg_idx_t'(k + 1), 5'd0, slot_addr(k)));
    end
    for (int k = 0; k < 4; k++) begin
      prog.push_back(lw(reg_idx_t'(k + 5), 5'd0, slot_addr(k)));
    end
    prog.push_back(rtype(F7_BASE, F3_ADD, 5'd9, 5'd5, 5'd6));
    prog.push_back(rtype(F7_BASE, F3_ADD, 5'd9, 5'd9, 5'd7));
    prog.push_back(rtype(F7_BASE, F3_ADD, 5'd9, 5'd9, 5'd8));
    prog.push_back(sw(5'd9, 5'd0, slot_addr(4)));
    prog.push_back(32'h0);
    load_program();
    wait_halt();
    for (int k = 0; k < 4; k++) begin
      check_slot(k, vals[k], $sformatf("stored word %0d", k));
    end
    check_slot(4, sum, "sum of loaded words");
  endtask

  task automatic branches_jal();
    word_t      va;
    word_t      vb;
    word_t      opnd;
    word_t      exp [4];
    logic [2:0] f3;
    reg_idx_t   rs2;
    logic       taken;
    addr_t      jal_addr;
    tests_run++;
    va = $urandom() % 1024;
    vb = va + 32'd1;
    prog.delete();
    prog.push_back(addi(5'd1, 5'd0, va[11:0]));
    prog.push_back(addi(5'd2, 5'd0, va[11:0]));
    prog.push_back(addi(5'd3, 5'd0, vb[11:0]));
    prog.push_back(addi(5'd10, 5'd0, 12'h123));  // Marker value
    for (int k = 0; k < 4; k++) begin
      f3    = (k < 2) ? F3_BEQ : F3_BNE;
      rs2   = (k % 2 == 0) ? 5'd2 : 5'd3;
      opnd  = (rs2 == 5'd2) ? va : vb;
      taken = (f3 == F3_BEQ) ? (va == opnd) : (va != opnd);
      exp[k] = taken ? fill_word(mem_idx_t'(DATA_BASE + k)) : 32'h123;
      prog.push_back(branch(f3, 5'd1, rs2, 13'd8));  // Skips the next store
      prog.push_back(sw(5'd10, 5'd0, slot_addr(k)));
    end
    jal_addr = addr_t'(prog.size() * 4);
    prog.push_back(jal(5'd5, 21'd8));
    prog.push_back(sw(5'd10, 5'd0, slot_addr(4)));
    prog.push_back(sw(5'd5, 5'd0, slot_addr(5)));
    prog.push_back(32'h0);
    load_program();
    wait_halt();
    for (int k = 0; k < 4; k++) begin
      check_slot(k, exp[k], $sformatf("branch marker %0d", k));
    end
    check_slot(4, fill_word(mem_idx_t'(DATA_BASE + 4)), "store after JAL");
    check_slot(5, jal_addr + 32'd4, "JAL link");
  endtask

  task automatic zero_reg();
    logic [11:0] imm;
    tests_run++;
    imm = 12'($urandom()) | 12'h001;
    prog.delete();
    prog.push_back(addi(5'd0, 5'd0, imm));
    prog.push_back(addi(5'd1, 5'd0, imm));
    prog.push_back(rtype(F7_BASE, F3_ADD, 5'd0, 5'd1, 5'd1));
    prog.push_back(sw(5'd0, 5'd0, slot_addr(0)));
    prog.push_back(32'h0);
    load_program();
    wait_halt();
    check_slot(0, 32'h0, "x0 after writes");
  endtask

  task automatic invalid_halt();
    addr_t halt_pc;
    logic  seen_bad;
    tests_run++;
    prog.delete();
    prog.push_back(addi(5'd1, 5'd0, 12'd1));
    prog.push_back(addi(5'd1, 5'd1, 12'd1));
    prog.push_back(32'h0010_0073);  // EBREAK is outside the subset
    load_program();
    wait_halt();
    halt_pc  = pc;
    seen_bad = 1'b0;
    repeat (50) begin
      @(posedge clk);
      #1;
      if (!seen_bad && (pc !== halt_pc || invalid !== 1'b1)) begin
        seen_bad = 1'b1;
        flag_error($sformatf("halt not held: pc=%08h invalid=%b", pc, invalid));
      end
    end
    rst = 1'b1;
    @(posedge clk);
    #1;
    if (pc !== '0 || invalid !== 1'b0) begin
      flag_error($sformatf("reset after halt: pc=%08h invalid=%b", pc, invalid));
    end
  endtask

  initial begin
    rst        = 1'b1;
    host_we    = 1'b0;
    host_idx   = '0;
    host_wdata = '0;
    errors     = 0;
    tests_run  = 0;
    void'($urandom(22500));
    reset_state();
    alu_ops();
    load_store();
    branches_jal();
    zero_reg();
    invalid_halt();
    $display("Tests run: %0d, errors: %0d", tests_run, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

//--- project.f
design/cpu_pkg.sv
design/reg_file.sv
design/fetch.sv
design/execute.sv
design/core.sv
design/unified_mem.sv
design/cpu_top.sv
dv/cpu_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build with Verilator, run, and judge the result from the log
cd "$(dirname "$0")" || exit 1
verilator --binary -j 0 --top-module cpu_tb -f project.f -o cpu_tb_sim \
  && ./obj_dir/cpu_tb_sim > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "Verification failed" sim.log && exit 1 || exit 0
